// File: Makefile
# Verilator flow for the gshare branch predictor
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST ?= filelist.f
TOP ?= branchPredictorTb
RTL_TOP ?= branchPredictor
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= sim failed
PASS_MSG ?= sim passed
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run is judged by the log, a crash without a pass line also fails
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bpPkg.sv
`default_nettype none

// Shared widths, depths and counter codes for the gshare predictor
package bpPkg;

	localparam int pcWidth = 32; // Fetch program counter width
	localparam int indexWidth = 8; // PHT index width, also the GHR length
	localparam int phtDepth = 256; // One counter per index value
	localparam int queueDepth = 8; // Branches that may be in flight at once
	localparam int queuePtrWidth = 3; // Enough to address queueDepth entries
	localparam int ctrWidth = 2; // Every PHT counter is two bits
	localparam int statWidth = 16; // Branch and mispredict statistics

	// Two-bit saturating counter codes, MSB gives the direction
	localparam logic [ctrWidth-1:0] ctrStrongNot = 2'b00;
	localparam logic [ctrWidth-1:0] ctrWeakNot = 2'b01;
	localparam logic [ctrWidth-1:0] ctrWeakTaken = 2'b10; // PHT comes out of reset here
	localparam logic [ctrWidth-1:0] ctrStrongTaken = 2'b11;

	// Moves a counter one step toward the actual outcome and sticks at either end
	function automatic logic [ctrWidth-1:0] nextCounter(
		input logic [ctrWidth-1:0] ctr,
		input logic taken
	);
		logic [ctrWidth-1:0] next;
		case (ctr)
			ctrStrongNot: begin
				next = taken ? ctrWeakNot : ctrStrongNot; // Saturates low
			end
			ctrWeakNot: begin
				next = taken ? ctrWeakTaken : ctrStrongNot;
			end
			ctrWeakTaken: begin
				next = taken ? ctrStrongTaken : ctrWeakNot;
			end
			default: begin
				next = taken ? ctrStrongTaken : ctrWeakTaken; // Saturates high
			end
		endcase
		return next;
	endfunction

endpackage

`default_nettype wire

// File: branchCommit.sv
`timescale 1ns/1ps
`default_nettype none

// Commit stage, retires the oldest branch when its outcome arrives
// Trains the PHT, feeds the history and keeps the statistics
module branchCommit import bpPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic resolveValid, // Outcome of the oldest branch is here
	input wire logic resolveTaken,
	input wire logic [indexWidth-1:0] headIndex, // Entry the branch was predicted from
	input wire logic [ctrWidth-1:0] headState, // Counter as read at prediction time
	input wire logic headTaken, // Direction that was predicted
	output logic phtWrite,
	output logic [indexWidth-1:0] phtWriteIndex,
	output logic [ctrWidth-1:0] phtWriteState,
	output logic historyShift,
	output logic historyBit,
	output logic mispredict, // One-cycle pulse after a wrong prediction resolves
	output logic [statWidth-1:0] branchCount,
	output logic [statWidth-1:0] mispredictCount
);

	logic wrongWay; // Outcome differs from the predicted direction

	// Training starts from the captured counter
	// A later write to the same entry by a younger branch can be overwritten here
	assign phtWrite = resolveValid;
	assign phtWriteIndex = headIndex;
	assign phtWriteState = nextCounter(headState, resolveTaken);

	// The actual outcome goes into the history, never the prediction
	assign historyShift = resolveValid;
	assign historyBit = resolveTaken;

	assign wrongWay = resolveValid && (resolveTaken != headTaken);

	// Pulse and counters move on the same edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mispredict <= 1'b0;
			branchCount <= '0;
			mispredictCount <= '0;
		end else begin
			mispredict <= wrongWay;
			if (resolveValid) begin
				branchCount <= branchCount + 1'b1; // Wraps silently past 16 bits
			end
			if (wrongWay) begin
				mispredictCount <= mispredictCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: branchIndex.sv
`timescale 1ns/1ps
`default_nettype none

// Index stage of the predictor
// Keeps the global history and hashes it with the fetch PC to address the PHT
module branchIndex import bpPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic fetchValid, // Fetch strobe from the front end
	input wire logic [pcWidth-1:0] fetchPc,
	input wire logic historyShift, // Commit stage retires a branch this cycle
	input wire logic historyBit, // Actual outcome of that branch
	output logic [indexWidth-1:0] phtIndex, // Combinational read address into the PHT
	output logic predValid, // Prediction payload is valid this cycle
	output logic [indexWidth-1:0] predIndex // Index the prediction was read from
);

	logic [indexWidth-1:0] ghr; // Global history, newest outcome in bit 0

	// Only the low PC bits take part in the hash
	assign phtIndex = fetchPc[indexWidth-1:0] ^ ghr;

	// History only moves when a branch commits
	// Fetches made while branches are in flight see the older history
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ghr <= '0;
		end else if (historyShift) begin
			ghr <= {ghr[indexWidth-2:0], historyBit}; // Oldest outcome drops off the top
		end
	end

	// Strobe is delayed one cycle so it lines up with the registered PHT read
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			predValid <= 1'b0;
		end else begin
			predValid <= fetchValid;
		end
	end

	// The index travels with the prediction so commit can write the same entry back
	always_ff @(posedge clk) begin
		if (fetchValid) begin
			predIndex <= phtIndex;
		end
	end

endmodule

`default_nettype wire

// File: branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

// Top level of the gshare predictor
// Index stage and PHT produce, the queue holds in-flight branches, commit consumes
module branchPredictor import bpPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic fetchValid, // Must stay low while queueFull is high
	input wire logic [pcWidth-1:0] fetchPc,
	input wire logic resolveValid, // Outcomes arrive in program order
	input wire logic resolveTaken,
	output logic predValid, // One cycle after fetchValid
	output logic predTaken,
	output logic queueFull,
	output logic [statWidth-1:0] branchCount,
	output logic [statWidth-1:0] mispredictCount,
	output logic mispredict
);

	logic [indexWidth-1:0] phtIndex; // Hashed read address
	logic [indexWidth-1:0] predIndex; // Address the prediction came from
	logic [ctrWidth-1:0] predState; // Counter read for the prediction
	logic historyShift;
	logic historyBit;
	logic phtWrite;
	logic [indexWidth-1:0] phtWriteIndex;
	logic [ctrWidth-1:0] phtWriteState;
	logic [indexWidth-1:0] headIndex;
	logic [ctrWidth-1:0] headState;
	logic headTaken;

	branchIndex index (
		.clk, .rstN, .fetchValid, .fetchPc, .historyShift, .historyBit,
		.phtIndex, .predValid, .predIndex
	);

	gshare pht (
		.clk, .rstN, .readIndex(phtIndex), .phtWrite, .phtWriteIndex, .phtWriteState,
		.state(predState)
	);

	assign predTaken = predState[ctrWidth-1]; // Upper half of the counter range means taken

	branchQueue queue (
		.clk, .rstN,
		.push(predValid), .pushIndex(predIndex), .pushState(predState), .pushTaken(predTaken),
		.pop(resolveValid),
		.headIndex, .headState, .headTaken, .queueEmpty(), .queueFull
	);

	branchCommit commit (
		.clk, .rstN, .resolveValid, .resolveTaken, .headIndex, .headState, .headTaken,
		.phtWrite, .phtWriteIndex, .phtWriteState, .historyShift, .historyBit,
		.mispredict, .branchCount, .mispredictCount
	);

	// Back-pressure is only a level, the front end has to honour it
	assertFetchWhenFull: assert property (
		@(posedge clk) disable iff (!rstN)
		fetchValid |-> !queueFull
	) else $error("Fetch while the branch queue is full");

endmodule

`default_nettype wire

// File: branchPredictorTb.sv
`timescale 1ns/1ps
`default_nettype none

// Self-checking testbench for the gshare predictor
// A model of the PHT, the history and the in-flight queue predicts every output each cycle
module branchPredictorTb import bpPkg::*; ();

	logic clk;
	logic rstN;
	logic fetchValid;
	logic [pcWidth-1:0] fetchPc;
	logic resolveValid;
	logic resolveTaken;
	logic predValid;
	logic predTaken;
	logic queueFull;
	logic [statWidth-1:0] branchCount;
	logic [statWidth-1:0] mispredictCount;
	logic mispredict;

	logic [1:0] modelPht [phtDepth]; // Reference pattern table
	logic [indexWidth-1:0] modelGhr; // Newest outcome in bit 0
	logic [indexWidth-1:0] qIndex [$]; // In-flight branches, oldest first
	logic [1:0] qState [$];
	logic qTaken [$];
	logic pendValid; // Prediction read at the last edge, queued at the next one
	logic [indexWidth-1:0] pendIndex;
	logic [1:0] pendState;

	logic expPredValid; // Expected outputs after the latest edge
	logic expPredTaken;
	logic expMispredict;
	logic expFull;
	logic [statWidth-1:0] expBranchCount;
	logic [statWidth-1:0] expMispredictCount;

	int errorCount;
	int checkCount;
	int testErrors;
	int fetchCount; // Fetches sampled by the DUT
	int mispredictSeen;

	tbClock clockGen (.clk);

	branchPredictor UUT (
		.clk, .rstN, .fetchValid, .fetchPc, .resolveValid, .resolveTaken,
		.predValid, .predTaken, .queueFull, .branchCount, .mispredictCount, .mispredict
	);

	// Counter moves one step toward the outcome and stops at 00 or 11
	function automatic logic [1:0] trainCounter(input logic [1:0] ctr, input logic taken);
		logic [1:0] result;
		result = ctr;
		if (taken && ctr != 2'b11) begin
			result = ctr + 2'd1;
		end else if (!taken && ctr != 2'b00) begin
			result = ctr - 2'd1;
		end
		return result;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		errorCount++;
		testErrors++;
	endtask

	task automatic reportFailure(input string what);
		$display("Failure: %s at %0t", what, $time);
		errorCount++;
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		$display("test %-20s %s, %0d errors", name, (testErrors == 0) ? "ok" : "FAIL", testErrors);
		testErrors = 0;
	endtask

	task automatic resetModel();
		for (int i = 0; i < phtDepth; i++) begin
			modelPht[i] = 2'b10; // Every entry leaves reset weakly taken
		end
		modelGhr = '0;
		qIndex.delete();
		qState.delete();
		qTaken.delete();
		pendValid = 1'b0;
		pendIndex = '0;
		pendState = '0;
		expPredValid = 1'b0;
		expPredTaken = 1'b0;
		expMispredict = 1'b0;
		expFull = 1'b0;
		expBranchCount = '0;
		expMispredictCount = '0;
	endtask

	// Advances the model by one edge using the inputs the DUT samples at that edge
	task automatic applyEdge();
		logic [indexWidth-1:0] readIndex;
		logic [1:0] readState;
		logic [indexWidth-1:0] headIndex;
		logic [1:0] headState;
		logic headTaken;
		readIndex = fetchPc[indexWidth-1:0] ^ modelGhr; // Fetch sees the history from before the edge
		readState = modelPht[readIndex]; // And the table from before any write
		if (fetchValid) begin
			fetchCount++;
		end
		expMispredict = 1'b0;
		if (resolveValid) begin
			if (qIndex.size() == 0) begin
				reportFailure("resolve driven with no branch in flight");
			end else begin
				headIndex = qIndex.pop_front(); // Oldest branch retires
				headState = qState.pop_front();
				headTaken = qTaken.pop_front();
				modelPht[headIndex] = trainCounter(headState, resolveTaken);
				modelGhr = {modelGhr[indexWidth-2:0], resolveTaken};
				expBranchCount++;
				if (resolveTaken != headTaken) begin
					expMispredict = 1'b1;
					expMispredictCount++;
				end
			end
		end
		if (pendValid) begin // Last prediction joins the tail behind any pop
			qIndex.push_back(pendIndex);
			qState.push_back(pendState);
			qTaken.push_back(pendState[1]);
		end
		pendValid = fetchValid;
		pendIndex = readIndex;
		pendState = readState;
		expPredValid = fetchValid;
		expPredTaken = readState[1]; // Upper half of the counter range predicts taken
		expFull = (qIndex.size() + (fetchValid ? 1 : 0)) >= queueDepth; // Pending push counted
	endtask

	task automatic checkOutputs();
		checkCount++;
		if (predValid !== expPredValid) begin
			reportMismatch("predValid", 32'(predValid), 32'(expPredValid));
		end
		if (expPredValid && predTaken !== expPredTaken) begin
			reportMismatch("predTaken", 32'(predTaken), 32'(expPredTaken));
		end
		if (mispredict !== expMispredict) begin
			reportMismatch("mispredict", 32'(mispredict), 32'(expMispredict));
		end
		if (mispredict === 1'b1) begin
			mispredictSeen++;
		end
		if (branchCount !== expBranchCount) begin
			reportMismatch("branchCount", 32'(branchCount), 32'(expBranchCount));
		end
		if (mispredictCount !== expMispredictCount) begin
			reportMismatch("mispredictCount", 32'(mispredictCount), 32'(expMispredictCount));
		end
		if (queueFull !== expFull) begin
			reportMismatch("queueFull", 32'(queueFull), 32'(expFull));
		end
	endtask

	// One clock of stimulus, gated so the front end never breaks the queue rules
	task automatic runCycle(input logic wantFetch, input logic [pcWidth-1:0] pc,
		input logic wantResolve, input logic outcome);
		@(posedge clk);
		applyEdge();
		fetchValid <= wantFetch && !expFull; // No fetch while the full level is up
		fetchPc <= pc;
		resolveValid <= wantResolve && (qIndex.size() > 0); // Only a queued branch resolves
		resolveTaken <= outcome;
		@(negedge clk); // Outputs have settled here
		checkOutputs();
	endtask

	// Resolves everything in flight, mode 0 not taken, 1 taken, 2 random
	task automatic drainWith(input int mode);
		int cycles;
		logic outcome;
		cycles = 0;
		while ((qIndex.size() > 0 || pendValid || fetchValid) && cycles < 64) begin
			outcome = (mode == 2) ? 1'($urandom) : (mode == 1);
			runCycle(1'b0, '0, 1'b1, outcome);
			cycles++;
		end
		if (qIndex.size() > 0 || pendValid || fetchValid) begin
			reportFailure("branch queue did not drain within 64 cycles");
		end
	endtask

	initial begin
		int waitCycles;
		logic sawTaken;
		logic sawNotTaken;
		logic lastTaken;
		logic [pcWidth-1:0] pc;
		void'($urandom(25573)); // One seed for the whole run
		errorCount = 0;
		checkCount = 0;
		testErrors = 0;
		fetchCount = 0;
		mispredictSeen = 0;
		lastTaken = 1'b1;
		sawTaken = 1'b0;
		sawNotTaken = 1'b0;
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchPc = '0;
		resolveValid = 1'b0;
		resolveTaken = 1'b0;
		resetModel();
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);

		// Outputs idle after reset, untrained table predicts taken
		checkOutputs();
		pc = $urandom;
		runCycle(1'b1, pc, 1'b0, 1'b0);
		waitCycles = 0;
		do begin
			runCycle(1'b0, pc, 1'b0, 1'b0);
			waitCycles++;
		end while (predValid !== 1'b1 && waitCycles < 8);
		if (predValid !== 1'b1) begin
			reportFailure("no prediction followed the first fetch");
		end else if (predTaken !== 1'b1) begin
			reportMismatch("predTaken", 32'(predTaken), 32'h1);
		end
		drainWith(1);
		finishTest("reset state");

		// Bursts of fetches, latency and index checked every cycle
		for (int burst = 0; burst < 6; burst++) begin
			for (int i = 0; i < 6; i++) begin
				runCycle(($urandom % 4) != 0, $urandom, 1'b0, 1'b0);
			end
			drainWith(2);
		end
		finishTest("latency and index");

		// Not-taken outcomes clear the history, then train one entry down
		pc = $urandom;
		for (int i = 0; i < 12; i++) begin
			runCycle(1'b1, pc, 1'b0, 1'b0);
			runCycle(1'b0, pc, 1'b0, 1'b0); // Prediction is visible now
			lastTaken = predTaken;
			drainWith(0);
		end
		if (lastTaken !== 1'b0) begin
			reportMismatch("predTaken", 32'(lastTaken), 32'h0);
		end
		finishTest("counter training");

		// Same PC as above, first with the cleared history on its trained entry
		// Taken outcomes then steer it onto other entries of the table
		for (int i = 0; i < 16; i++) begin
			runCycle(1'b1, pc, 1'b0, 1'b0);
			runCycle(1'b0, pc, 1'b0, 1'b0); // Prediction is visible now
			if (predTaken === 1'b1) begin
				sawTaken = 1'b1;
			end else begin
				sawNotTaken = 1'b1;
			end
			drainWith((i % 3 == 0) ? 1 : 2);
		end
		if (!(sawTaken && sawNotTaken)) begin
			reportFailure("predictions for a repeated PC never changed with the history");
		end
		finishTest("history effect");

		// Mixed traffic over a small PC pool so entries get trained and retrained
		mispredictSeen = 0;
		for (int i = 0; i < 400; i++) begin
			runCycle(($urandom % 4) != 0, ($urandom % 32) * 4, ($urandom % 3) != 0, 1'($urandom));
		end
		drainWith(2);
		if (mispredictSeen == 0) begin
			reportFailure("random traffic produced no mispredict pulse");
		end
		finishTest("mispredict stats");

		// Fill until the full level rises, hold, then drain in order
		fetchCount = 0;
		waitCycles = 0;
		do begin
			runCycle(1'b1, $urandom, 1'b0, 1'b0);
			waitCycles++;
		end while (queueFull !== 1'b1 && waitCycles < 20);
		if (queueFull !== 1'b1) begin
			reportFailure("queueFull never rose while fetching");
		end else if (fetchCount != queueDepth) begin
			reportMismatch("fetchCount", 32'(fetchCount), 32'(queueDepth));
		end
		repeat (4) runCycle(1'b1, $urandom, 1'b0, 1'b0); // Full level must hold while fetches wait
		waitCycles = 0;
		do begin
			runCycle(1'b0, '0, 1'b1, 1'($urandom));
			waitCycles++;
		end while (queueFull !== 1'b0 && waitCycles < 20);
		if (queueFull !== 1'b0) begin
			reportFailure("queueFull stayed high while draining");
		end
		drainWith(2);
		finishTest("queue back-pressure");

		repeat (4) runCycle(1'b0, '0, 1'b0, 1'b0);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: branchQueue.sv
`timescale 1ns/1ps
`default_nettype none

// In-order FIFO of predictions that are waiting for their outcome
// Each entry keeps the PHT index, the counter read at prediction time and the direction
module branchQueue import bpPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic push, // New prediction from the index stage
	input wire logic [indexWidth-1:0] pushIndex,
	input wire logic [ctrWidth-1:0] pushState,
	input wire logic pushTaken,
	input wire logic pop, // Oldest branch resolves this cycle
	output logic [indexWidth-1:0] headIndex, // Oldest in-flight branch
	output logic [ctrWidth-1:0] headState,
	output logic headTaken,
	output logic queueEmpty,
	output logic queueFull // Tells the front end to stop fetching
);

	// Payload storage
	logic [indexWidth-1:0] indexMem [queueDepth];
	logic [ctrWidth-1:0] stateMem [queueDepth];
	logic takenMem [queueDepth];

	logic [queuePtrWidth-1:0] wrPtr; // Next free slot
	logic [queuePtrWidth-1:0] rdPtr; // Oldest entry
	logic [queuePtrWidth:0] count; // Occupancy, one bit wider to hold a full queue
	logic [queuePtrWidth:0] level; // Occupancy with the pending push counted

	// Payload is written without reset, the pointers say what is live
	always_ff @(posedge clk) begin
		if (push) begin
			indexMem[wrPtr] <= pushIndex;
			stateMem[wrPtr] <= pushState;
			takenMem[wrPtr] <= pushTaken;
		end
	end

	// Pointers wrap by themselves since the depth is a power of two
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	// A push and a pop together leave the count unchanged
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is visible as soon as it is written
	assign headIndex = indexMem[rdPtr];
	assign headState = stateMem[rdPtr];
	assign headTaken = takenMem[rdPtr];

	assign queueEmpty = (count == '0);

	// A fetch accepted now pushes one cycle later
	// Counting the push in flight keeps room for that entry
	assign level = count + {{queuePtrWidth{1'b0}}, push};
	assign queueFull = level >= (queuePtrWidth+1)'(queueDepth);

	assertNoOverflow: assert property (
		@(posedge clk) disable iff (!rstN)
		push |-> count != (queuePtrWidth+1)'(queueDepth)
	) else $error("Push into a full branch queue");

	assertNoUnderflow: assert property (
		@(posedge clk) disable iff (!rstN)
		pop |-> !queueEmpty
	) else $error("Resolve with no branch in flight");

endmodule

`default_nettype wire

// File: filelist.f
bpPkg.sv
branchIndex.sv
gshare.sv
branchQueue.sv
branchCommit.sv
branchPredictor.sv
tbClock.sv
branchPredictorTb.sv

// File: gshare.sv
`timescale 1ns/1ps
`default_nettype none

// Pattern history table of two-bit saturating counters
// One synchronous read and one write per cycle
module gshare import bpPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [indexWidth-1:0] readIndex, // Hashed PC and history from the index stage
	input wire logic phtWrite, // Commit stage updates one entry
	input wire logic [indexWidth-1:0] phtWriteIndex,
	input wire logic [ctrWidth-1:0] phtWriteState,
	output logic [ctrWidth-1:0] state // Counter read last cycle, MSB is the direction
);

	logic [ctrWidth-1:0] patternTable [phtDepth];

	// Whole table starts at weakly taken so an untrained branch predicts taken
	// A write to the entry being read lands after the read samples it
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < phtDepth; i++) begin
				patternTable[i] <= ctrWeakTaken;
			end
		end else if (phtWrite) begin
			patternTable[phtWriteIndex] <= phtWriteState;
		end
	end

	// Read every cycle whether or not a fetch is present
	// The index stage's strobe says which reads matter
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= ctrWeakTaken;
		end else begin
			state <= patternTable[readIndex]; // Old contents on a same-edge write
		end
	end

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench, 10 ns period
module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0; // Known level before the first edge
	end

	// Half period of 5 ns
	always begin
		#5 clk = ~clk;
	end

endmodule

`default_nettype wire
